//--- vlog.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_register.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/forwarding_unit.sv
verilog/execute_stage.sv
verilog/cpu_top.sv
bench/tb_clock.sv
bench/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator.
# The exit status is the simulator's: nonzero on any failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module cpu_tb \
  -f vlog.f \
  -o cpu_sim

./obj_dir/cpu_sim

//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int n_instr      = 2000;
  localparam int period_ns    = 100;
  localparam int reset_cycles = 4;
  // edges from the issue sample to the retire edge
  localparam int latency      = 3;
  // worst case four cycles per instruction, plus slack
  localparam int timeout_ns   = (n_instr * 4 + 100 + reset_cycles) * period_ns;

  logic    clk;
  logic    rst_n;
  logic    issue_valid;
  instr_t  issue_instr;
  logic    retire_valid;
  retire_t retire;

  retire_t     exp_q[$];
  int          issue_edge_q[$];
  int          edge_cnt = 0;
  int          n_retired = 0;
  logic [31:0] rng_state;
  word_t       model_regs [32];

  tb_clock #(.period_ns(period_ns), .reset_cycles(reset_cycles)) clock_i (
    .clk(clk),
    .rst_n(rst_n)
  );

  cpu_top dut_i (
    .clk(clk),
    .rst_n(rst_n),
    .issue_valid(issue_valid),
    .issue_instr(issue_instr),
    .retire_valid(retire_valid),
    .retire(retire)
  );

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // small register range keeps dependencies frequent
  function automatic instr_t random_instr();
    logic [31:0] r;
    logic [31:0] s;
    instr_t      instr;
    r = next_rand();
    s = next_rand();
    instr = instr_t'(r);
    case (s[3:0])
      4'd14:   instr.opcode = op_nop;
      4'd15:   instr.opcode = opcode_e'(6'd12 + {1'b0, s[14:10]});
      default: instr.opcode = opcode_e'(6'd1 + (s[9:4] % 6'd11));
    endcase
    instr.rs = {2'b00, s[17:15]};
    instr.rt = {2'b00, s[20:18]};
    // immediates keep the full random low half
    if (!(instr.opcode inside {op_addi, op_andi, op_ori})) begin
      instr.rd = {2'b00, s[23:21]};
    end
    return instr;
  endfunction

  // executes one instruction on the model register file
  function automatic retire_t reference_exec(instr_t instr);
    retire_t r;
    word_t   a;
    word_t   b;
    word_t   imm_z;
    a = (instr.rs == 5'd0) ? 32'd0 : model_regs[instr.rs];
    b = (instr.rt == 5'd0) ? 32'd0 : model_regs[instr.rt];
    imm_z = {16'd0, instr[15:0]};
    r.reg_write = 1'b1;
    r.dst = instr.rd;
    r.data = '0;
    case (instr.opcode)
      op_add: r.data = a + b;
      op_sub: r.data = a - b;
      op_and: r.data = a & b;
      op_or:  r.data = a | b;
      op_xor: r.data = a ^ b;
      op_slt: r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_sll: r.data = b << instr.shamt;
      op_srl: r.data = b >> instr.shamt;
      op_addi: begin
        r.data = a + imm_z;
        r.dst = instr.rt;
      end
      op_andi: begin
        r.data = a & imm_z;
        r.dst = instr.rt;
      end
      op_ori: begin
        r.data = a | imm_z;
        r.dst = instr.rt;
      end
      default: r.reg_write = 1'b0;
    endcase
    return r;
  endfunction

  task automatic check_retire(retire_t got, retire_t exp);
    if (got.reg_write !== exp.reg_write ||
        (exp.reg_write && (got.dst !== exp.dst || got.data !== exp.data))) begin
      stop_on_error($sformatf(
        "Mismatch at %0t: retire we=%0b dst=%0d data=%08h, expected we=%0b dst=%0d data=%08h",
        $time, got.reg_write, got.dst, got.data, exp.reg_write, exp.dst, exp.data));
    end
  endtask

  task automatic check_latency(int got_edge, int exp_edge);
    if (got_edge != exp_edge) begin
      stop_on_error($sformatf("Mismatch at %0t: retired at edge %0d, expected edge %0d",
                              $time, got_edge, exp_edge));
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    instr_t      instr;
    retire_t     exp;
    logic [31:0] rr;
    int          gap;
    int          i;
    rng_state = 32'd50582;
    issue_valid = 1'b0;
    issue_instr = '0;
    for (i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    wait (rst_n === 1'b1);
    // a few idle cycles, nothing may retire here
    repeat (4) @(posedge clk);
    for (i = 0; i < n_instr; i++) begin
      instr = random_instr();
      exp = reference_exec(instr);
      if (exp.reg_write && exp.dst != 5'd0) begin
        model_regs[exp.dst] = exp.data;
      end
      exp_q.push_back(exp);
      issue_valid <= 1'b1;
      issue_instr <= instr;
      @(posedge clk);
      rr = next_rand();
      gap = rr[2] ? 0 : int'(rr[1:0]);
      if (gap > 0) begin
        issue_valid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
    end
    issue_valid <= 1'b0;
    repeat (latency + 4) @(posedge clk);
    if (exp_q.size() != 0 || issue_edge_q.size() != 0) begin
      stop_on_error($sformatf("%0d instructions never retired", exp_q.size()));
    end else begin
      $display("retired %0d instructions", n_retired);
      $display("Verification passed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // compare, sampled mid-cycle
  ////////////////////////////////////////

  always @(negedge clk) begin : compare
    retire_t exp;
    int      issued;
    if (rst_n !== 1'b1) begin
      if (retire_valid !== 1'b0) begin
        stop_on_error("retire_valid is not low during reset");
      end
    end else begin
      // sampled by the DUT at the next edge
      if (issue_valid === 1'b1) begin
        issue_edge_q.push_back(edge_cnt + 1);
      end
      if (retire_valid === 1'b1) begin
        if (exp_q.size() == 0 || issue_edge_q.size() == 0) begin
          stop_on_error("retire seen with no instruction outstanding");
        end
        exp = exp_q.pop_front();
        issued = issue_edge_q.pop_front();
        check_retire(retire, exp);
        check_latency(edge_cnt, issued + latency);
        n_retired++;
      end else if (retire_valid !== 1'b0) begin
        stop_on_error("retire_valid is unknown");
      end
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    stop_on_error("timeout, the run did not finish in time");
  end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // release on an edge so the flops see a clean deassert
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  wire                clk,
  input  wire                rst_n,
  input  logic               issue_valid,
  input  isa_pkg::instr_t    issue_instr,
  output logic               retire_valid,
  output pipe_pkg::retire_t  retire
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic     if_id_valid;
  instr_t   if_id_instr;
  logic     id_ex_valid;
  id_ex_t   id_ex_d;
  id_ex_t   id_ex_q;
  logic     ex_mem_valid;
  ex_mem_t  ex_mem_d;
  ex_mem_t  ex_mem_q;
  mem_wb_t  mem_wb_q;
  reg_idx_t rs;
  reg_idx_t rt;
  word_t    reg_read_a;
  word_t    reg_read_b;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;

  ////////////////////////////////////////
  // fetch / decode
  ////////////////////////////////////////

  stage_register #(.payload_t(instr_t)) if_id_reg (
    .clk(clk), .rst_n(rst_n),
    .in_valid(issue_valid), .in_data(issue_instr),
    .out_valid(if_id_valid), .out_data(if_id_instr)
  );

  decode_stage decode_i (
    .valid(if_id_valid), .instr(if_id_instr),
    .reg_read_a(reg_read_a), .reg_read_b(reg_read_b),
    .rs(rs), .rt(rt), .id_ex(id_ex_d)
  );

  // written from mem_wb, same edge as retire handoff
  register_file regfile_i (
    .clk(clk), .rst_n(rst_n),
    .rd_addr_a(rs), .rd_addr_b(rt),
    .rd_data_a(reg_read_a), .rd_data_b(reg_read_b),
    .wr_en(retire_valid & mem_wb_q.reg_write),
    .wr_addr(mem_wb_q.dst), .wr_data(mem_wb_q.result)
  );

  stage_register #(.payload_t(id_ex_t)) id_ex_reg (
    .clk(clk), .rst_n(rst_n),
    .in_valid(if_id_valid), .in_data(id_ex_d),
    .out_valid(id_ex_valid), .out_data(id_ex_q)
  );

  ////////////////////////////////////////
  // execute / mem / writeback
  ////////////////////////////////////////

  forwarding_unit fwd_i (
    .id_ex_rs(id_ex_q.rs), .id_ex_rt(id_ex_q.rt),
    .ex_mem_valid(ex_mem_valid), .mem_wb_valid(retire_valid),
    .ex_mem(ex_mem_q), .mem_wb(mem_wb_q),
    .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  execute_stage execute_i (
    .id_ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .ex_mem_result(ex_mem_q.result), .mem_wb_result(mem_wb_q.result),
    .ex_mem(ex_mem_d)
  );

  stage_register #(.payload_t(ex_mem_t)) ex_mem_reg (
    .clk(clk), .rst_n(rst_n),
    .in_valid(id_ex_valid), .in_data(ex_mem_d),
    .out_valid(ex_mem_valid), .out_data(ex_mem_q)
  );

  // no memory access, plain delay stage
  stage_register #(.payload_t(mem_wb_t)) mem_wb_reg (
    .clk(clk), .rst_n(rst_n),
    .in_valid(ex_mem_valid), .in_data(ex_mem_q),
    .out_valid(retire_valid), .out_data(mem_wb_q)
  );

  assign retire = retire_t'(mem_wb_q);

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  pipe_pkg::id_ex_t   id_ex,
  input  pipe_pkg::fwd_sel_e fwd_a,
  input  pipe_pkg::fwd_sel_e fwd_b,
  input  isa_pkg::word_t     ex_mem_result,
  input  isa_pkg::word_t     mem_wb_result,
  output pipe_pkg::ex_mem_t  ex_mem
);

  import isa_pkg::*;
  import pipe_pkg::*;

  word_t op_a;
  word_t rt_fwd;
  word_t op_b;
  word_t result;

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t em_val,
                                    word_t mw_val);
    case (sel)
      fwd_ex_mem: return em_val;
      fwd_mem_wb: return mw_val;
      default:    return reg_val;
    endcase
  endfunction

  ////////////////////////////////////////
  // operand select
  ////////////////////////////////////////

  always_comb begin
    op_a   = fwd_mux(fwd_a, id_ex.rs_val, ex_mem_result, mem_wb_result);
    rt_fwd = fwd_mux(fwd_b, id_ex.rt_val, ex_mem_result, mem_wb_result);
    if (id_ex.ctrl.shift_src) begin
      op_b = {27'd0, id_ex.shamt};
    end else if (id_ex.ctrl.alu_src) begin
      // immediates are zero-extended
      op_b = {16'd0, id_ex.imm};
    end else begin
      op_b = rt_fwd;
    end
  end

  ////////////////////////////////////////
  // alu
  ////////////////////////////////////////

  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_add: result = op_a + op_b;
      alu_sub: result = op_a - op_b;
      alu_and: result = op_a & op_b;
      alu_or:  result = op_a | op_b;
      alu_xor: result = op_a ^ op_b;
      alu_slt: result = {31'd0, $signed(op_a) < $signed(op_b)};
      // shifts move rt, count comes in on op_b
      alu_sll: result = rt_fwd << op_b[4:0];
      alu_srl: result = rt_fwd >> op_b[4:0];
      default: result = '0;
    endcase
  end

  always_comb begin
    ex_mem.reg_write = id_ex.ctrl.reg_write;
    ex_mem.dst       = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
    ex_mem.result    = result;
  end

endmodule

`default_nettype wire

//--- verilog/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
  input  isa_pkg::reg_idx_t   id_ex_rs,
  input  isa_pkg::reg_idx_t   id_ex_rt,
  input  logic                ex_mem_valid,
  input  logic                mem_wb_valid,
  input  pipe_pkg::ex_mem_t   ex_mem,
  input  pipe_pkg::mem_wb_t   mem_wb,
  output pipe_pkg::fwd_sel_e  fwd_a,
  output pipe_pkg::fwd_sel_e  fwd_b
);

  import isa_pkg::*;
  import pipe_pkg::*;

  // stage holds a live write to src
  function automatic logic hit(reg_idx_t src, logic stage_valid, logic stage_rw,
                               reg_idx_t stage_dst);
    return stage_valid && stage_rw && stage_dst != '0 && stage_dst == src;
  endfunction

  // youngest producer wins
  function automatic fwd_sel_e pick(reg_idx_t src);
    if (hit(src, ex_mem_valid, ex_mem.reg_write, ex_mem.dst)) begin
      return fwd_ex_mem;
    end
    if (hit(src, mem_wb_valid, mem_wb.reg_write, mem_wb.dst)) begin
      return fwd_mem_wb;
    end
    return fwd_reg;
  endfunction

  always_comb begin
    fwd_a = pick(id_ex_rs);
    fwd_b = pick(id_ex_rt);
  end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic              valid,
  input  isa_pkg::instr_t   instr,
  input  isa_pkg::word_t    reg_read_a,
  input  isa_pkg::word_t    reg_read_b,
  output isa_pkg::reg_idx_t rs,
  output isa_pkg::reg_idx_t rt,
  output pipe_pkg::id_ex_t  id_ex
);

  import isa_pkg::*;
  import pipe_pkg::*;

  ctrl_t ctrl;

  assign rs = instr.rs;
  assign rt = instr.rt;

  ////////////////////////////////////////
  // control unit
  ////////////////////////////////////////

  always_comb begin
    ctrl = '{alu_op: alu_add, default: 1'b0};
    case (instr.opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
        case (instr.opcode)
          op_sub:  ctrl.alu_op = alu_sub;
          op_and:  ctrl.alu_op = alu_and;
          op_or:   ctrl.alu_op = alu_or;
          op_xor:  ctrl.alu_op = alu_xor;
          op_slt:  ctrl.alu_op = alu_slt;
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_sll, op_srl: begin
        ctrl.alu_op    = (instr.opcode == op_sll) ? alu_sll : alu_srl;
        ctrl.reg_dst   = 1'b1;
        ctrl.shift_src = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      // immediates write rt
      op_addi, op_andi, op_ori: begin
        case (instr.opcode)
          op_andi: ctrl.alu_op = alu_and;
          op_ori:  ctrl.alu_op = alu_or;
          default: ctrl.alu_op = alu_add;
        endcase
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      default: begin
        ctrl.reg_write = 1'b0;
      end
    endcase
    // bubble never writes
    if (!valid) begin
      ctrl.reg_write = 1'b0;
    end
  end

  ////////////////////////////////////////
  // payload to id_ex
  ////////////////////////////////////////

  always_comb begin
    id_ex.ctrl   = ctrl;
    id_ex.rs     = instr.rs;
    id_ex.rt     = instr.rt;
    id_ex.rd     = instr.rd;
    id_ex.shamt  = instr.shamt;
    id_ex.imm    = instr_imm(instr);
    id_ex.rs_val = reg_read_a;
    id_ex.rt_val = reg_read_b;
  end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire               clk,
  input  wire               rst_n,
  input  isa_pkg::reg_idx_t rd_addr_a,
  input  isa_pkg::reg_idx_t rd_addr_b,
  output isa_pkg::word_t    rd_data_a,
  output isa_pkg::word_t    rd_data_b,
  input  logic              wr_en,
  input  isa_pkg::reg_idx_t wr_addr,
  input  isa_pkg::word_t    wr_data
);

  import isa_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write-through so decode sees the retiring value
  function automatic word_t read_port(reg_idx_t addr, logic we, reg_idx_t waddr,
                                      word_t wdata, word_t stored);
    if (addr == '0) begin
      return '0;
    end
    if (we && waddr == addr) begin
      return wdata;
    end
    return stored;
  endfunction

  always_comb begin
    rd_data_a = read_port(rd_addr_a, wr_en, wr_addr, wr_data, regs[rd_addr_a]);
    rd_data_b = read_port(rd_addr_b, wr_en, wr_addr, wr_data, regs[rd_addr_b]);
  end

  zero_reg_stays_zero: assert property (
    @(posedge clk) disable iff (!rst_n) regs[0] == '0
  );

endmodule

`default_nettype wire

//--- verilog/stage_register.sv
`timescale 1ns/1ps
`default_nettype none

module stage_register #(
  parameter type payload_t = logic
) (
  input  wire      clk,
  input  wire      rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // data holds still on idle cycles
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_data <= in_data;
    end
  end

  out_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid)
  );

endmodule

`default_nettype wire

//--- verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  import isa_pkg::*;

  // decoded control bits, travel with the instruction
  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;
    logic    reg_dst;
    logic    shift_src;
    logic    reg_write;
  } ctrl_t;

  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    shamt_t   shamt;
    imm_t     imm;
    word_t    rs_val;
    word_t    rt_val;
  } id_ex_t;

  typedef struct packed {
    logic     reg_write;
    reg_idx_t dst;
    word_t    result;
  } ex_mem_t;

  typedef struct packed {
    logic     reg_write;
    reg_idx_t dst;
    word_t    result;
  } mem_wb_t;

  // operand source for execute
  typedef enum logic [1:0] {
    fwd_reg    = 2'd0,
    fwd_ex_mem = 2'd1,
    fwd_mem_wb = 2'd2
  } fwd_sel_e;

  // same layout as mem_wb_t
  typedef struct packed {
    logic     reg_write;
    reg_idx_t dst;
    word_t    data;
  } retire_t;

endpackage

`default_nettype wire

//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

  ////////////////////////////////////////
  // basic widths
  ////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [15:0] imm_t;

  ////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////

  // values outside this list decode as nop
  typedef enum logic [5:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_xor  = 6'd5,
    op_slt  = 6'd6,
    op_sll  = 6'd7,
    op_srl  = 6'd8,
    op_addi = 6'd9,
    op_andi = 6'd10,
    op_ori  = 6'd11
  } opcode_e;

  // instruction word, top bit first
  typedef struct packed {
    opcode_e    opcode;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    shamt_t     shamt;
    logic [5:0] unused;
  } instr_t;

  // immediate sits on the low 16 bits
  function automatic imm_t instr_imm(instr_t instr);
    return instr[15:0];
  endfunction

  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_slt = 4'd5,
    alu_sll = 4'd6,
    alu_srl = 4'd7
  } alu_op_e;

endpackage

`default_nettype wire
